// File: all.f
+incdir+src
+incdir+test
src/div_pkg.sv
src/div_operand_prep.sv
src/div_restoring_core.sv
src/div_result_fixup.sv
src/div_unit.sv
test/tb_div_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the divide unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/100ps -Wno-fatal \
  --top-module tb_div_unit -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_div_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^ALL CHECKS PASSED$"; then
  exit 0
fi
exit 1

// File: src/div_config.svh
// divide unit configuration
// datapath widths and one-hot operation codes

`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// datapath widths
`define DIV_XLEN 64
`define DIV_WLEN 32

// one-hot operation codes
`define DIV_OP_DIV   8'b1000_0000  // signed 64 bit quotient
`define DIV_OP_DIVU  8'b0100_0000
`define DIV_OP_DIVUW 8'b0010_0000
`define DIV_OP_DIVW  8'b0001_0000
`define DIV_OP_REM   8'b0000_1000  // signed 64 bit remainder
`define DIV_OP_REMU  8'b0000_0100
`define DIV_OP_REMUW 8'b0000_0010
`define DIV_OP_REMW  8'b0000_0001

`endif

// File: src/div_operand_prep.sv
// divide operand preparation
// extends word operands, forms magnitudes and sign flags,
// and catches divide by zero and signed overflow
`timescale 1ns/100ps
`include "div_config.svh"

module div_operand_prep (
  input  div_pkg::div_op_t   op_i,
  input  div_pkg::xlen_t     dividend_i,
  input  div_pkg::xlen_t     divisor_i,
  output div_pkg::xlen_t     mag_dividend_o,
  output div_pkg::xlen_t     mag_divisor_o,
  output logic               neg_quot_o,
  output logic               neg_rem_o,
  output div_pkg::step_cnt_t steps_o,
  output logic               special_o,
  output div_pkg::xlen_t     special_result_o
);
  import div_pkg::*;

  logic  is_word;
  logic  is_signed;
  logic  is_rem;
  xlen_t dvd_sext;   // low word sign-extended
  xlen_t dvs_sext;
  xlen_t dvd_ext;    // operand as the op sees it
  xlen_t dvs_ext;
  xlen_t dvd_abs;
  xlen_t dvs_abs;
  xlen_t dvd_arch;   // dividend value as returned by special cases
  xlen_t min_neg;    // most negative value for this width
  logic  dvd_neg;
  logic  dvs_neg;
  logic  div_zero;
  logic  div_ovf;

  // ==================================================
  // op decode
  assign is_word   = op_i inside {`DIV_OP_DIVW, `DIV_OP_DIVUW, `DIV_OP_REMW, `DIV_OP_REMUW};
  assign is_signed = op_i inside {`DIV_OP_DIV, `DIV_OP_DIVW, `DIV_OP_REM, `DIV_OP_REMW};
  assign is_rem    = op_i inside {`DIV_OP_REM, `DIV_OP_REMU, `DIV_OP_REMW, `DIV_OP_REMUW};

  // ==================================================
  // extension and magnitudes
  assign dvd_sext = {{(`DIV_XLEN-`DIV_WLEN){dividend_i[`DIV_WLEN-1]}},
                     dividend_i[`DIV_WLEN-1:0]};
  assign dvs_sext = {{(`DIV_XLEN-`DIV_WLEN){divisor_i[`DIV_WLEN-1]}},
                     divisor_i[`DIV_WLEN-1:0]};

  always_comb begin
    if (!is_word) begin
      dvd_ext = dividend_i;
      dvs_ext = divisor_i;
    end else if (is_signed) begin
      dvd_ext = dvd_sext;
      dvs_ext = dvs_sext;
    end else begin
      // unsigned word ops zero-extend
      dvd_ext = {{(`DIV_XLEN-`DIV_WLEN){1'b0}}, dividend_i[`DIV_WLEN-1:0]};
      dvs_ext = {{(`DIV_XLEN-`DIV_WLEN){1'b0}}, divisor_i[`DIV_WLEN-1:0]};
    end
  end

  assign dvd_neg = is_signed & dvd_ext[`DIV_XLEN-1];
  assign dvs_neg = is_signed & dvs_ext[`DIV_XLEN-1];
  assign dvd_abs = dvd_neg ? -dvd_ext : dvd_ext;
  assign dvs_abs = dvs_neg ? -dvs_ext : dvs_ext;

  // word dividend goes to the top half so 32 steps are enough
  assign mag_dividend_o = is_word ? {dvd_abs[`DIV_WLEN-1:0], {(`DIV_XLEN-`DIV_WLEN){1'b0}}}
                                  : dvd_abs;
  assign mag_divisor_o  = dvs_abs;
  assign neg_quot_o     = dvd_neg ^ dvs_neg;
  assign neg_rem_o      = dvd_neg;
  assign steps_o        = is_word ? step_cnt_t'(`DIV_WLEN) : step_cnt_t'(`DIV_XLEN);

  // ==================================================
  // special cases
  assign dvd_arch = is_word ? dvd_sext : dividend_i;
  assign min_neg  = ~((xlen_t'(1) << (is_word ? `DIV_WLEN-1 : `DIV_XLEN-1)) - xlen_t'(1));
  assign div_zero = is_word ? (divisor_i[`DIV_WLEN-1:0] == '0) : (divisor_i == '0);
  assign div_ovf  = is_signed & (dvd_ext == min_neg) & (&dvs_ext);

  assign special_o = div_zero | div_ovf;

  always_comb begin
    special_result_o = '0;
    if (div_zero) begin
      special_result_o = is_rem ? dvd_arch : '1;  // quotient all ones
    end else if (div_ovf) begin
      special_result_o = is_rem ? '0 : dvd_arch;
    end
  end

endmodule

// File: src/div_pkg.sv
// divide unit package
// shared vector types and the control state encoding

`include "div_config.svh"

package div_pkg;

  // ==================================================
  // data types
  typedef logic [`DIV_XLEN-1:0]   xlen_t;   // one register word
  typedef logic [2*`DIV_XLEN-1:0] dword_t;  // partial remainder and quotient

  typedef logic [7:0] div_op_t;    // one-hot op code
  typedef logic [6:0] step_cnt_t;  // holds up to 64 steps

  // ==================================================
  // control states
  typedef enum logic [1:0] {
    DIV_IDLE   = 2'b00,  // waiting for a start
    DIV_BUSY   = 2'b01,  // iterating
    DIV_FINISH = 2'b10   // result held until taken
  } div_state_t;

endpackage

// File: src/div_restoring_core.sv
// restoring divide core
// one quotient bit per cycle on unsigned magnitudes
`timescale 1ns/100ps
`include "div_config.svh"

module div_restoring_core (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               load_i,
  input  div_pkg::xlen_t     dividend_i,
  input  div_pkg::xlen_t     divisor_i,
  input  div_pkg::step_cnt_t steps_i,
  output div_pkg::xlen_t     quotient_o,
  output div_pkg::xlen_t     remainder_o,
  output logic               done_o
);
  import div_pkg::*;

  dword_t    acc_q;      // {partial remainder, dividend -> quotient}
  xlen_t     divisor_q;
  step_cnt_t cnt_q;

  logic [`DIV_XLEN:0]   trial;  // shifted remainder with carry out
  logic [`DIV_XLEN+1:0] diff;
  logic                 fits;   // next quotient bit

  // ==================================================
  // trial subtraction
  assign trial = {acc_q[2*`DIV_XLEN-1:`DIV_XLEN], acc_q[`DIV_XLEN-1]};
  assign diff  = {1'b0, trial} - {2'b00, divisor_q};
  assign fits  = ~diff[`DIV_XLEN+1];

  // ==================================================
  // step counter
  always_ff @(posedge clk) begin
    if (rst_n) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= steps_i;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // ==================================================
  // datapath registers
  always_ff @(posedge clk) begin
    if (load_i) begin
      acc_q     <= {{`DIV_XLEN{1'b0}}, dividend_i};  // remainder starts at zero
      divisor_q <= divisor_i;
    end else if (cnt_q != '0) begin
      // keep difference or restore the shifted remainder
      acc_q[2*`DIV_XLEN-1:`DIV_XLEN] <= fits ? diff[`DIV_XLEN-1:0] : trial[`DIV_XLEN-1:0];
      acc_q[`DIV_XLEN-1:0]           <= {acc_q[`DIV_XLEN-2:0], fits};
    end
  end

  assign quotient_o  = acc_q[`DIV_XLEN-1:0];
  assign remainder_o = acc_q[2*`DIV_XLEN-1:`DIV_XLEN];
  assign done_o      = (cnt_q == '0);

endmodule

// File: src/div_result_fixup.sv
// divide result fixup
// restores signs, picks quotient or remainder, extends word results
`timescale 1ns/100ps
`include "div_config.svh"

module div_result_fixup (
  input  div_pkg::div_op_t op_i,
  input  div_pkg::xlen_t   quotient_i,
  input  div_pkg::xlen_t   remainder_i,
  input  logic             neg_quot_i,
  input  logic             neg_rem_i,
  output div_pkg::xlen_t   result_o
);
  import div_pkg::*;

  logic  is_rem;
  logic  is_word;
  xlen_t quot_fix;
  xlen_t rem_fix;
  xlen_t pick;

  assign is_rem  = op_i inside {`DIV_OP_REM, `DIV_OP_REMU, `DIV_OP_REMW, `DIV_OP_REMUW};
  assign is_word = op_i inside {`DIV_OP_DIVW, `DIV_OP_DIVUW, `DIV_OP_REMW, `DIV_OP_REMUW};

  // quotient negative when signs differ
  assign quot_fix = neg_quot_i ? -quotient_i : quotient_i;
  // remainder follows the dividend sign
  assign rem_fix  = neg_rem_i ? -remainder_i : remainder_i;

  assign pick = is_rem ? rem_fix : quot_fix;

  // word results are sign-extended from bit 31
  assign result_o = is_word ? {{(`DIV_XLEN-`DIV_WLEN){pick[`DIV_WLEN-1]}},
                               pick[`DIV_WLEN-1:0]}
                            : pick;

endmodule

// File: src/div_unit.sv
// iterative divide unit for the M extension
// control FSM around operand prep, restoring core and result fixup
`timescale 1ns/100ps

module div_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             div_valid_i,
  input  div_pkg::div_op_t div_op_i,
  input  div_pkg::xlen_t   dividend_i,
  input  div_pkg::xlen_t   divisor_i,
  input  logic             result_ready_i,
  output div_pkg::xlen_t   result_o,
  output logic             div_stall_o,
  output logic             result_ok_o
);
  import div_pkg::*;

  div_state_t state_q;
  div_state_t state_d;
  div_op_t    op_q;        // op of the running division
  logic       neg_quot_q;
  logic       neg_rem_q;
  xlen_t      result_q;    // output register

  xlen_t      mag_dividend;
  xlen_t      mag_divisor;
  xlen_t      special_result;
  xlen_t      core_quot;
  xlen_t      core_rem;
  xlen_t      fixed_result;
  step_cnt_t  steps;
  logic       neg_quot;
  logic       neg_rem;
  logic       special;
  logic       core_done;
  logic       accept;
  logic       core_load;

  assign accept    = (state_q == DIV_IDLE) && div_valid_i;
  assign core_load = accept && !special;  // special cases skip the core

  // ==================================================
  // datapath
  div_operand_prep i_prep (
    .op_i             (div_op_i),
    .dividend_i       (dividend_i),
    .divisor_i        (divisor_i),
    .mag_dividend_o   (mag_dividend),
    .mag_divisor_o    (mag_divisor),
    .neg_quot_o       (neg_quot),
    .neg_rem_o        (neg_rem),
    .steps_o          (steps),
    .special_o        (special),
    .special_result_o (special_result)
  );

  div_restoring_core i_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_i      (core_load),
    .dividend_i  (mag_dividend),
    .divisor_i   (mag_divisor),
    .steps_i     (steps),
    .quotient_o  (core_quot),
    .remainder_o (core_rem),
    .done_o      (core_done)
  );

  div_result_fixup i_fixup (
    .op_i        (op_q),
    .quotient_i  (core_quot),
    .remainder_i (core_rem),
    .neg_quot_i  (neg_quot_q),
    .neg_rem_i   (neg_rem_q),
    .result_o    (fixed_result)
  );

  // ==================================================
  // control FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      DIV_IDLE:   if (accept) state_d = special ? DIV_FINISH : DIV_BUSY;
      DIV_BUSY:   if (core_done) state_d = DIV_FINISH;
      DIV_FINISH: if (result_ready_i) state_d = DIV_IDLE;  // hold until taken
      default:    state_d = DIV_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= DIV_IDLE;
      op_q    <= '0;
    end else begin
      state_q <= state_d;
      if (core_load) op_q <= div_op_i;
    end
  end

  // sign flags and result register
  always_ff @(posedge clk) begin
    if (core_load) begin
      neg_quot_q <= neg_quot;
      neg_rem_q  <= neg_rem;
    end
    if (accept && special) begin
      result_q <= special_result;
    end else if (state_q == DIV_BUSY && core_done) begin
      result_q <= fixed_result;
    end
  end

  // ==================================================
  // outputs
  assign result_ok_o = (state_q == DIV_FINISH);
  assign div_stall_o = core_load || (state_q == DIV_BUSY);
  assign result_o    = result_ok_o ? result_q : '0;

endmodule

// File: test/div_ref_model.svh
// divide reference model
// expected result of each M-extension divide op from the ISA rules

`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

function automatic logic [`DIV_XLEN-1:0] expected_result(input logic [7:0] op,
                                                        input logic [`DIV_XLEN-1:0] a,
                                                        input logic [`DIV_XLEN-1:0] b);
  longint          sa;
  longint          sb;
  longint unsigned ua;
  longint unsigned ub;
  int              swa;
  int              swb;
  int unsigned     uwa;
  int unsigned     uwb;
  logic            is_word;
  logic            is_signed;
  logic            is_rem;
  logic [31:0]     w;
  logic [63:0]     r;
  sa  = a;
  sb  = b;
  ua  = a;
  ub  = b;
  swa = a[31:0];
  swb = b[31:0];
  uwa = a[31:0];
  uwb = b[31:0];
  is_word   = op inside {`DIV_OP_DIVW, `DIV_OP_DIVUW, `DIV_OP_REMW, `DIV_OP_REMUW};
  is_signed = op inside {`DIV_OP_DIV, `DIV_OP_DIVW, `DIV_OP_REM, `DIV_OP_REMW};
  is_rem    = op inside {`DIV_OP_REM, `DIV_OP_REMU, `DIV_OP_REMW, `DIV_OP_REMUW};
  if (is_word) begin
    if (b[31:0] == 32'h0) w = is_rem ? a[31:0] : 32'hffff_ffff;
    else if (is_signed && a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff)
      w = is_rem ? 32'h0 : a[31:0];  // overflow
    else if (is_signed) w = is_rem ? swa % swb : swa / swb;
    else w = is_rem ? uwa % uwb : uwa / uwb;
    r = {{32{w[31]}}, w};
  end else begin
    if (b == 64'h0) r = is_rem ? a : '1;
    else if (is_signed && a == {1'b1, 63'h0} && b == '1) r = is_rem ? 64'h0 : a;
    else if (is_signed) r = is_rem ? sa % sb : sa / sb;
    else r = is_rem ? ua % ub : ua / ub;
  end
  return r;
endfunction

`endif

// File: test/tb_div_unit.sv
// testbench for the iterative divide unit
// random and corner-case operations checked against the reference model
`timescale 1ns/100ps
`include "div_config.svh"

module tb_div_unit;
  import div_pkg::*;

  `include "div_ref_model.svh"

  logic    clk = 1'b0;
  logic    rst_n;
  logic    div_valid_i;
  div_op_t div_op_i;
  xlen_t   dividend_i;
  xlen_t   divisor_i;
  logic    result_ready_i;
  xlen_t   result_o;
  logic    div_stall_o;
  logic    result_ok_o;

  int errors = 0;
  int checks = 0;

  div_op_t long_ops [4] = '{`DIV_OP_DIV, `DIV_OP_DIVU, `DIV_OP_REM, `DIV_OP_REMU};
  div_op_t word_ops [4] = '{`DIV_OP_DIVW, `DIV_OP_DIVUW, `DIV_OP_REMW, `DIV_OP_REMUW};

  always #2 clk = ~clk;  // 4 ns period

  div_unit i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_op_i       (div_op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .result_ready_i (result_ready_i),
    .result_o       (result_o),
    .div_stall_o    (div_stall_o),
    .result_ok_o    (result_ok_o)
  );

  // ==================================================
  // helpers
  task automatic tick();
    @(posedge clk);
    #0.5;  // drive and sample away from the edge
  endtask

  task automatic check_value(input string name, input xlen_t exp, input xlen_t act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic expect_level(input string name, input logic exp, input logic act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED %s expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  function automatic xlen_t any_word();
    return {$urandom, $urandom};
  endfunction

  function automatic xlen_t random_divisor();
    xlen_t v;
    v = any_word() >> ($urandom % 64);  // spread the quotient sizes
    if (v == '0) v = 1;
    return v;
  endfunction

  // divide by zero or signed overflow, judged on the low word for word ops
  function automatic logic special_case(input div_op_t op, input xlen_t a, input xlen_t b);
    logic word;
    logic sgn;
    word = op inside {`DIV_OP_DIVW, `DIV_OP_DIVUW, `DIV_OP_REMW, `DIV_OP_REMUW};
    sgn  = op inside {`DIV_OP_DIV, `DIV_OP_DIVW, `DIV_OP_REM, `DIV_OP_REMW};
    if (word) begin
      return (b[31:0] == 32'h0) ||
             (sgn && a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff);
    end
    return (b == '0) || (sgn && a == {1'b1, 63'h0} && b == '1);
  endfunction

  function automatic string op_name(input div_op_t op);
    case (op)
      `DIV_OP_DIV:   return "div";
      `DIV_OP_DIVU:  return "divu";
      `DIV_OP_DIVW:  return "divw";
      `DIV_OP_DIVUW: return "divuw";
      `DIV_OP_REM:   return "rem";
      `DIV_OP_REMU:  return "remu";
      `DIV_OP_REMW:  return "remw";
      default:       return "remuw";
    endcase
  endfunction

  task automatic wait_for_result(input string name, output logic ok_seen);
    int cycles;
    cycles = 0;
    while (!result_ok_o && cycles < 100) begin
      expect_level({name, " stall while busy"}, 1'b1, div_stall_o);
      check_value({name, " result before ok"}, '0, result_o);
      tick();
      cycles++;
    end
    ok_seen = result_ok_o;
    if (!ok_seen) begin
      $display("timeout: result_ok_o never rose for %s", name);
      errors++;
    end
  endtask

  // one operation, optionally held in finish for hold cycles
  task automatic run_op(input string tag, input div_op_t op, input xlen_t a, input xlen_t b,
                        input int hold);
    string name;
    xlen_t exp;
    logic  special;
    logic  ok_seen;
    name    = {op_name(op), " ", tag};
    exp     = expected_result(op, a, b);
    special = special_case(op, a, b);
    div_op_i    = op;
    dividend_i  = a;
    divisor_i   = b;
    div_valid_i = 1'b1;
    #1;  // combinational stall in the idle cycle
    if (!special) expect_level({name, " stall at accept"}, 1'b1, div_stall_o);
    tick();
    div_valid_i = 1'b0;
    dividend_i  = any_word();  // operands only matter at acceptance
    divisor_i   = any_word();
    if (special) expect_level({name, " ok after accept"}, 1'b1, result_ok_o);
    wait_for_result(name, ok_seen);
    if (ok_seen) begin
      check_value(name, exp, result_o);
      expect_level({name, " stall in finish"}, 1'b0, div_stall_o);
      for (int i = 0; i < hold; i++) begin
        div_valid_i = (i == 0);  // must be ignored
        tick();
        expect_level({name, " ok held"}, 1'b1, result_ok_o);
        check_value({name, " result held"}, exp, result_o);
      end
      div_valid_i    = 1'b0;
      result_ready_i = 1'b1;
      tick();
      result_ready_i = 1'b0;
      expect_level({name, " ok after ready"}, 1'b0, result_ok_o);
      check_value({name, " result after ready"}, '0, result_o);
    end
  endtask

  // ==================================================
  // stimulus
  initial begin
    xlen_t a;
    xlen_t b;
    void'($urandom(32'h0f72dd16));
    rst_n          = 1'b1;
    div_valid_i    = 1'b0;
    div_op_i       = `DIV_OP_DIVU;
    dividend_i     = '0;
    divisor_i      = '0;
    result_ready_i = 1'b0;
    repeat (10) @(posedge clk);
    #0.5;
    rst_n = 1'b0;

    expect_level("reset ok", 1'b0, result_ok_o);
    expect_level("reset stall", 1'b0, div_stall_o);
    check_value("reset result", '0, result_o);

    for (int i = 0; i < 10; i++) begin
      a = any_word();
      b = random_divisor();
      run_op($sformatf("unsigned %0d", i), `DIV_OP_DIVU, a, b, 0);
      run_op($sformatf("unsigned %0d", i), `DIV_OP_REMU, a, b, 0);
    end

    // all four sign combinations
    for (int i = 0; i < 12; i++) begin
      a = any_word() >> 1;
      b = random_divisor() >> 1;
      if (b == '0) b = 1;
      if (i[0]) a = -a;
      if (i[1]) b = -b;
      run_op($sformatf("signed %0d", i), `DIV_OP_DIV, a, b, 0);
      run_op($sformatf("signed %0d", i), `DIV_OP_REM, a, b, 0);
    end

    // garbage in the upper operand halves
    for (int i = 0; i < 6; i++) begin
      a = any_word();
      b = {$urandom, $urandom >> ($urandom % 32)};
      if (b[31:0] == 32'h0) b[0] = 1'b1;
      foreach (word_ops[j]) run_op($sformatf("word %0d", i), word_ops[j], a, b, 0);
    end

    // ==================================================
    // special results
    foreach (long_ops[j]) run_op("zero divisor", long_ops[j], any_word(), '0, 0);
    foreach (word_ops[j]) run_op("zero divisor", word_ops[j], any_word(), {$urandom, 32'h0}, 0);
    run_op("overflow", `DIV_OP_DIV, {1'b1, 63'h0}, '1, 0);
    run_op("overflow", `DIV_OP_REM, {1'b1, 63'h0}, '1, 0);
    run_op("overflow", `DIV_OP_DIVW, {$urandom, 32'h8000_0000}, {$urandom, 32'hffff_ffff}, 0);
    run_op("overflow", `DIV_OP_REMW, {$urandom, 32'h8000_0000}, {$urandom, 32'hffff_ffff}, 0);

    // result held while the consumer stalls
    for (int i = 0; i < 4; i++) begin
      run_op($sformatf("back-pressure %0d", i), i[0] ? word_ops[i] : long_ops[i],
             any_word(), random_divisor(), 1 + $urandom % 8);
    end

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
